// ==== hdl/mini_mcu_pkg.sv ====
// mini_mcu shared definitions
// bus structs, width types, memory map and bus constants
package mini_mcu_pkg;

  // widths with a meaning
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0] be_t;

  typedef struct packed {
    logic  req;
    logic  we;
    be_t   be;
    addr_t addr;
    data_t wdata;
  } obi_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    data_t rdata;
  } obi_resp_t;

  localparam int NUM_MASTERS = 2;

  // banked ram geometry
  localparam int NUM_BANKS = 2;
  localparam int BANK_WORDS = 256;

  typedef logic [$clog2(NUM_BANKS)-1:0] bank_idx_t;
  typedef logic [$clog2(BANK_WORDS)-1:0] word_idx_t;

  // memory map
  localparam addr_t RAM_BASE = 32'h0000_0000;
  localparam addr_t RAM_SIZE = addr_t'(NUM_BANKS * BANK_WORDS * 4);
  localparam addr_t AO_BASE = 32'h2000_0000;
  localparam addr_t AO_SIZE = 32'h0000_0010;

  // always-on register offsets
  localparam addr_t AO_EXIT_VALUE_OFS = 32'h0;
  localparam addr_t AO_EXIT_VALID_OFS = 32'h4;
  localparam addr_t AO_BOOT_SEL_OFS = 32'h8;

  // read value from unmapped space
  localparam data_t ERR_RDATA = 32'hbadc0de0;

  // bus target codes
  typedef logic [1:0] target_t;
  localparam target_t TGT_RAM = 2'd0;
  localparam target_t TGT_AO = 2'd1;
  localparam target_t TGT_ERR = 2'd2;

endpackage

// ==== hdl/system_bus.sv ====
// system bus
// decodes master addresses, arbitrates per target with master 0 first,
// routes responses back and answers unmapped accesses
`timescale 1ns/10ps

module system_bus (
  input  logic clk_i,
  input  logic rst_i,
  input  mini_mcu_pkg::obi_req_t  [mini_mcu_pkg::NUM_MASTERS-1:0] master_req_i,
  output mini_mcu_pkg::obi_resp_t [mini_mcu_pkg::NUM_MASTERS-1:0] master_resp_o,
  output mini_mcu_pkg::obi_req_t  ram_req_o,
  input  mini_mcu_pkg::obi_resp_t ram_resp_i,
  output mini_mcu_pkg::obi_req_t  ao_req_o,
  input  mini_mcu_pkg::obi_resp_t ao_resp_i
);

  localparam int NM = mini_mcu_pkg::NUM_MASTERS;

  mini_mcu_pkg::target_t tgt [NM];
  mini_mcu_pkg::target_t pend_tgt_q [NM];
  logic [NM-1:0] won;
  logic [NM-1:0] gnt;
  logic [NM-1:0] pend_q;
  mini_mcu_pkg::obi_req_t err_req;
  logic err_rvalid_q;
  mini_mcu_pkg::data_t err_rdata_q;

  function automatic mini_mcu_pkg::target_t decode(mini_mcu_pkg::addr_t addr);
    mini_mcu_pkg::target_t t;
    t = mini_mcu_pkg::TGT_ERR;
    if ((addr - mini_mcu_pkg::RAM_BASE) < mini_mcu_pkg::RAM_SIZE) begin
      t = mini_mcu_pkg::TGT_RAM;
    end else if ((addr - mini_mcu_pkg::AO_BASE) < mini_mcu_pkg::AO_SIZE) begin
      t = mini_mcu_pkg::TGT_AO;
    end
    return t;
  endfunction

  // a master loses if a lower index wants the same target
  always_comb begin
    for (int m = 0; m < NM; m++) begin
      tgt[m] = decode(master_req_i[m].addr);
      won[m] = master_req_i[m].req;
      for (int j = 0; j < m; j++) begin
        if (master_req_i[j].req && decode(master_req_i[j].addr) == tgt[m]) begin
          won[m] = 1'b0;
        end
      end
    end
  end

  // forward the winner of each target
  always_comb begin
    ram_req_o = '0;
    ao_req_o = '0;
    err_req = '0;
    for (int m = 0; m < NM; m++) begin
      if (won[m]) begin
        case (tgt[m])
          mini_mcu_pkg::TGT_RAM: ram_req_o = master_req_i[m];
          mini_mcu_pkg::TGT_AO: ao_req_o = master_req_i[m];
          default: err_req = master_req_i[m];
        endcase
      end
    end
  end

  always_comb begin
    master_resp_o = '0;
    for (int m = 0; m < NM; m++) begin
      case (tgt[m])
        mini_mcu_pkg::TGT_RAM: gnt[m] = won[m] && ram_resp_i.gnt;
        mini_mcu_pkg::TGT_AO: gnt[m] = won[m] && ao_resp_i.gnt;
        default: gnt[m] = won[m];
      endcase
      master_resp_o[m].gnt = gnt[m];
      if (pend_q[m]) begin
        case (pend_tgt_q[m])
          mini_mcu_pkg::TGT_RAM: begin
            master_resp_o[m].rvalid = ram_resp_i.rvalid;
            master_resp_o[m].rdata = ram_resp_i.rdata;
          end
          mini_mcu_pkg::TGT_AO: begin
            master_resp_o[m].rvalid = ao_resp_i.rvalid;
            master_resp_o[m].rdata = ao_resp_i.rdata;
          end
          default: begin
            master_resp_o[m].rvalid = err_rvalid_q;
            master_resp_o[m].rdata = err_rdata_q;
          end
        endcase
      end
    end
  end

  // which target owes each master a response
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pend_q <= '0;
      err_rvalid_q <= 1'b0;
    end else begin
      pend_q <= gnt;
      err_rvalid_q <= err_req.req;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int m = 0; m < NM; m++) begin
      if (gnt[m]) begin
        pend_tgt_q[m] <= tgt[m];
      end
    end
    // unmapped writes are dropped and answer zero
    err_rdata_q <= err_req.we ? '0 : mini_mcu_pkg::ERR_RDATA;
  end

  for (genvar t = int'(mini_mcu_pkg::TGT_RAM); t <= int'(mini_mcu_pkg::TGT_ERR);
       t++) begin : g_tgt_chk
    logic [NM-1:0] hit;
    for (genvar m = 0; m < NM; m++) begin : g_hit
      assign hit[m] = gnt[m] && (tgt[m] == mini_mcu_pkg::target_t'(t));
    end
    a_one_grant: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(hit));
  end

  // targets answer exactly one cycle after each grant
  for (genvar m = 0; m < NM; m++) begin : g_rsp_chk
    a_rvalid_after_gnt: assert property (
      @(posedge clk_i) disable iff (rst_i)
      master_resp_o[m].rvalid == ($past(gnt[m]) && !$past(rst_i))
    );
  end

endmodule

// ==== hdl/memory_subsystem.sv ====
// banked on-chip RAM
// byte-enabled writes, reads answered one cycle after the grant
`timescale 1ns/10ps

module memory_subsystem (
  input  logic clk_i,
  input  logic rst_i,
  input  mini_mcu_pkg::obi_req_t  ram_req_i,
  output mini_mcu_pkg::obi_resp_t ram_resp_o
);

  localparam int WORD_LSB = 2;
  localparam int BANK_LSB = WORD_LSB + $bits(mini_mcu_pkg::word_idx_t);
  localparam int NB = $bits(mini_mcu_pkg::be_t);

  mini_mcu_pkg::data_t mem_q [mini_mcu_pkg::NUM_BANKS][mini_mcu_pkg::BANK_WORDS];
  mini_mcu_pkg::bank_idx_t bank_idx;
  mini_mcu_pkg::word_idx_t word_idx;
  mini_mcu_pkg::data_t rdata_q;
  logic rvalid_q;

  // bank select sits just above the word index
  assign word_idx = ram_req_i.addr[WORD_LSB +: $bits(mini_mcu_pkg::word_idx_t)];
  assign bank_idx = ram_req_i.addr[BANK_LSB +: $bits(mini_mcu_pkg::bank_idx_t)];

  always_ff @(posedge clk_i) begin
    if (ram_req_i.req && ram_req_i.we) begin
      for (int b = 0; b < NB; b++) begin
        if (ram_req_i.be[b]) begin
          mem_q[bank_idx][word_idx][8*b +: 8] <= ram_req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // read data, zero for writes
  always_ff @(posedge clk_i) begin
    if (ram_req_i.req && !ram_req_i.we) begin
      rdata_q <= mem_q[bank_idx][word_idx];
    end else begin
      rdata_q <= '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= ram_req_i.req;
    end
  end

  assign ram_resp_o.gnt = ram_req_i.req;
  assign ram_resp_o.rvalid = rvalid_q;
  assign ram_resp_o.rdata = rdata_q;

  // bus decode must keep ram traffic inside the array
  a_addr_in_ram: assert property (
    @(posedge clk_i) disable iff (rst_i)
    ram_resp_o.gnt |-> (ram_req_i.addr - mini_mcu_pkg::RAM_BASE) < mini_mcu_pkg::RAM_SIZE
  );

endmodule

// ==== hdl/ao_peripheral_subsystem.sv ====
// always-on peripheral block
// exit value, sticky exit flag and boot select readback
`timescale 1ns/10ps

module ao_peripheral_subsystem (
  input  logic clk_i,
  input  logic rst_i,
  input  mini_mcu_pkg::obi_req_t  slave_req_i,
  output mini_mcu_pkg::obi_resp_t slave_resp_o,
  input  logic boot_select_i,
  output mini_mcu_pkg::data_t exit_value_o,
  output logic exit_valid_o
);

  mini_mcu_pkg::addr_t ofs;
  mini_mcu_pkg::data_t exit_value_q;
  mini_mcu_pkg::data_t rdata_q;
  logic exit_valid_q;
  logic rvalid_q;
  logic wr;

  assign ofs = slave_req_i.addr - mini_mcu_pkg::AO_BASE;
  assign wr = slave_req_i.req && slave_req_i.we;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exit_value_q <= '0;
      exit_valid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= slave_req_i.req;
      if (wr && ofs == mini_mcu_pkg::AO_EXIT_VALUE_OFS) begin
        for (int b = 0; b < $bits(mini_mcu_pkg::be_t); b++) begin
          if (slave_req_i.be[b]) begin
            exit_value_q[8*b +: 8] <= slave_req_i.wdata[8*b +: 8];
          end
        end
      end
      // sticky until reset
      if (wr && ofs == mini_mcu_pkg::AO_EXIT_VALID_OFS && slave_req_i.wdata[0]) begin
        exit_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q <= '0;
    if (slave_req_i.req && !slave_req_i.we) begin
      case (ofs)
        mini_mcu_pkg::AO_EXIT_VALUE_OFS: rdata_q <= exit_value_q;
        mini_mcu_pkg::AO_EXIT_VALID_OFS: rdata_q <= {31'b0, exit_valid_q};
        mini_mcu_pkg::AO_BOOT_SEL_OFS: rdata_q <= {31'b0, boot_select_i};
        default: rdata_q <= '0;
      endcase
    end
  end

  assign slave_resp_o.gnt = slave_req_i.req;
  assign slave_resp_o.rvalid = rvalid_q;
  assign slave_resp_o.rdata = rdata_q;
  assign exit_value_o = exit_value_q;
  assign exit_valid_o = exit_valid_q;

  a_exit_sticky: assert property (
    @(posedge clk_i) $past(exit_valid_o) && !$past(rst_i) |-> exit_valid_o
  );

endmodule

// ==== hdl/mini_mcu.sv ====
// mini_mcu top level
// two bus masters sharing banked RAM and the always-on block
`timescale 1ns/10ps

module mini_mcu (
  input  logic clk_i,
  input  logic rst_i,
  input  logic boot_select_i,
  input  mini_mcu_pkg::obi_req_t  [mini_mcu_pkg::NUM_MASTERS-1:0] master_req_i,
  output mini_mcu_pkg::obi_resp_t [mini_mcu_pkg::NUM_MASTERS-1:0] master_resp_o,
  output mini_mcu_pkg::data_t exit_value_o,
  output logic exit_valid_o
);

  // ram signals
  mini_mcu_pkg::obi_req_t  ram_slave_req;
  mini_mcu_pkg::obi_resp_t ram_slave_resp;

  // always-on peripheral signals
  mini_mcu_pkg::obi_req_t  ao_peripheral_slave_req;
  mini_mcu_pkg::obi_resp_t ao_peripheral_slave_resp;

  system_bus system_bus_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .master_req_i (master_req_i),
    .master_resp_o(master_resp_o),
    .ram_req_o    (ram_slave_req),
    .ram_resp_i   (ram_slave_resp),
    .ao_req_o     (ao_peripheral_slave_req),
    .ao_resp_i    (ao_peripheral_slave_resp)
  );

  memory_subsystem memory_subsystem_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .ram_req_i (ram_slave_req),
    .ram_resp_o(ram_slave_resp)
  );

  ao_peripheral_subsystem ao_peripheral_subsystem_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .slave_req_i  (ao_peripheral_slave_req),
    .slave_resp_o (ao_peripheral_slave_resp),
    .boot_select_i(boot_select_i),
    .exit_value_o (exit_value_o),
    .exit_valid_o (exit_valid_o)
  );

endmodule

// ==== testbench/tb_mini_mcu.sv ====
// testbench for mini_mcu
// two bus masters checked against a model of RAM, always-on registers and decode
`timescale 1ns/10ps

module tb_mini_mcu;

  localparam time CLK_PERIOD = 100;
  localparam int NUM_XFERS = 65;
  localparam int RAM_WORDS = mini_mcu_pkg::NUM_BANKS * mini_mcu_pkg::BANK_WORDS;
  localparam int RAM_AW = $clog2(RAM_WORDS);

  logic clk = 1'b0;
  logic rst;
  logic boot_sel;
  mini_mcu_pkg::obi_req_t [mini_mcu_pkg::NUM_MASTERS-1:0] mreq;
  mini_mcu_pkg::obi_resp_t [mini_mcu_pkg::NUM_MASTERS-1:0] mresp;
  mini_mcu_pkg::data_t exit_value;
  logic exit_valid;

  // reference model state
  mini_mcu_pkg::data_t ram_m [RAM_WORDS];
  mini_mcu_pkg::data_t exit_value_m;
  logic exit_valid_m;

  // outstanding responses per master
  mini_mcu_pkg::data_t exp_mem [2][4];
  time grant_t [2][4];
  logic [1:0] wr_ptr [2];
  logic [1:0] rd_ptr [2];

  logic [31:0] lfsr = 32'h5a87;
  int n_errors = 0;
  int n_checks = 0;
  int w0;
  int w1;
  string test_name = "reset";

  mini_mcu dut (
    .clk_i        (clk),
    .rst_i        (rst),
    .boot_select_i(boot_sel),
    .master_req_i (mreq),
    .master_resp_o(mresp),
    .exit_value_o (exit_value),
    .exit_valid_o (exit_valid)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [RAM_AW-1:0] ram_word(input mini_mcu_pkg::addr_t adr);
    mini_mcu_pkg::addr_t w;
    w = (adr - mini_mcu_pkg::RAM_BASE) >> 2;
    return w[RAM_AW-1:0];
  endfunction

  // expected read value from the memory map rules
  function automatic mini_mcu_pkg::data_t ref_read(input mini_mcu_pkg::addr_t adr);
    mini_mcu_pkg::addr_t ofs;
    ofs = adr - mini_mcu_pkg::AO_BASE;
    if (adr - mini_mcu_pkg::RAM_BASE < mini_mcu_pkg::RAM_SIZE) return ram_m[ram_word(adr)];
    if (ofs >= mini_mcu_pkg::AO_SIZE) return mini_mcu_pkg::ERR_RDATA;
    if (ofs == mini_mcu_pkg::AO_EXIT_VALUE_OFS) return exit_value_m;
    if (ofs == mini_mcu_pkg::AO_EXIT_VALID_OFS) return mini_mcu_pkg::data_t'(exit_valid_m);
    if (ofs == mini_mcu_pkg::AO_BOOT_SEL_OFS) return mini_mcu_pkg::data_t'(boot_sel);
    return '0;
  endfunction

  function automatic void model_write(input mini_mcu_pkg::addr_t adr,
                                      input mini_mcu_pkg::data_t dat,
                                      input mini_mcu_pkg::be_t ben);
    mini_mcu_pkg::data_t mask;
    mini_mcu_pkg::addr_t ofs;
    for (int b = 0; b < 4; b++) begin
      mask[8*b +: 8] = {8{ben[b]}};
    end
    ofs = adr - mini_mcu_pkg::AO_BASE;
    if (adr - mini_mcu_pkg::RAM_BASE < mini_mcu_pkg::RAM_SIZE) begin
      ram_m[ram_word(adr)] = (ram_m[ram_word(adr)] & ~mask) | (dat & mask);
    end else if (ofs == mini_mcu_pkg::AO_EXIT_VALUE_OFS) begin
      exit_value_m = (exit_value_m & ~mask) | (dat & mask);
    end else if (ofs == mini_mcu_pkg::AO_EXIT_VALID_OFS && dat[0]) begin
      exit_valid_m = 1'b1;
    end
  endfunction

  task automatic check(input string name, input mini_mcu_pkg::data_t exp,
                       input mini_mcu_pkg::data_t act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // one request, held until granted; the response is checked elsewhere
  task automatic do_xfer(input logic m, input logic wr, input mini_mcu_pkg::addr_t adr,
                         input mini_mcu_pkg::data_t dat, input mini_mcu_pkg::be_t ben,
                         output int waits);
    waits = 0;
    mreq[m] = '{req: 1'b1, we: wr, be: ben, addr: adr, wdata: dat};
    @(posedge clk);
    while (!mresp[m].gnt) begin
      waits++;
      @(posedge clk);
    end
    if (wr) model_write(adr, dat, ben);
    exp_mem[m][wr_ptr[m]] = wr ? '0 : ref_read(adr);
    grant_t[m][wr_ptr[m]] = $time;
    wr_ptr[m]++;
    #1;
    mreq[m].req = 1'b0;
  endtask

  task automatic drain();
    while (wr_ptr[0] != rd_ptr[0] || wr_ptr[1] != rd_ptr[1]) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic collect(input logic m);
    if (mresp[m].rvalid) begin
      if (wr_ptr[m] == rd_ptr[m]) begin
        n_errors++;
        $display("master %0d got a response with no request outstanding", m);
      end else begin
        if ($time - grant_t[m][rd_ptr[m]] != CLK_PERIOD) begin
          n_errors++;
          $display("master %0d response did not follow its grant by one cycle", m);
        end
        check(test_name, exp_mem[m][rd_ptr[m]], mresp[m].rdata);
        rd_ptr[m]++;
      end
    end
  endtask

  // compare every response with the value recorded at its grant
  always @(posedge clk) begin
    if (!rst) begin
      collect(1'b0);
      collect(1'b1);
    end
  end

  initial begin
    int idx;
    mini_mcu_pkg::addr_t adr;
    mini_mcu_pkg::data_t dat;
    rst = 1'b1;
    boot_sel = 1'b0;
    mreq = '0;
    exit_value_m = '0;
    exit_valid_m = 1'b0;
    for (int m = 0; m < 2; m++) begin
      wr_ptr[m] = '0;
      rd_ptr[m] = '0;
    end
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    check("reset_handshake", '0, mini_mcu_pkg::data_t'({mresp[0].gnt, mresp[0].rvalid,
          mresp[1].gnt, mresp[1].rvalid, exit_valid}));
    check("reset_exit_value", '0, exit_value);

    // full word first, then a random byte merge, then a read the next cycle
    test_name = "ram_random";
    for (int i = 0; i < 16; i++) begin
      idx = (i % 2) * mini_mcu_pkg::BANK_WORDS + int'(lfsr_bits(8));
      adr = mini_mcu_pkg::RAM_BASE + mini_mcu_pkg::addr_t'(idx * 4);
      do_xfer(i[0], 1'b1, adr, lfsr_bits(32), 4'hf, w0);
      do_xfer(i[0], 1'b1, adr, lfsr_bits(32), mini_mcu_pkg::be_t'(lfsr_bits(4)), w0);
      do_xfer(i[0], 1'b0, adr, '0, '0, w0);
    end
    drain();

    test_name = "contention";
    fork
      do_xfer(1'b0, 1'b1, 32'h0000_0040, 32'h0bad_f00d, 4'hf, w0);
      do_xfer(1'b1, 1'b0, 32'h0000_0040, '0, '0, w1);
    join
    check("contention_m0_wait", '0, mini_mcu_pkg::data_t'(w0));
    check("contention_m1_wait", 32'd1, mini_mcu_pkg::data_t'(w1));
    drain();
    test_name = "ram_ao_parallel";
    fork
      do_xfer(1'b0, 1'b0, 32'h0000_0040, '0, '0, w0);
      do_xfer(1'b1, 1'b0, mini_mcu_pkg::AO_BASE, '0, '0, w1);
    join
    check("parallel_wait", '0, mini_mcu_pkg::data_t'(w0 + w1));
    drain();

    test_name = "unmapped";
    do_xfer(1'b0, 1'b1, mini_mcu_pkg::RAM_BASE, 32'h1234_5678, 4'hf, w0);
    do_xfer(1'b1, 1'b0, 32'h1000_0000, '0, '0, w1);
    do_xfer(1'b1, 1'b1, 32'h1000_0000, 32'hffff_ffff, 4'hf, w1);
    do_xfer(1'b0, 1'b1, mini_mcu_pkg::RAM_BASE + mini_mcu_pkg::RAM_SIZE, 32'hdead_beef,
            4'hf, w0);
    do_xfer(1'b0, 1'b0, mini_mcu_pkg::RAM_BASE, '0, '0, w0);
    do_xfer(1'b1, 1'b0, mini_mcu_pkg::AO_BASE, '0, '0, w1);
    drain();

    test_name = "exit_regs";
    dat = lfsr_bits(32);
    adr = mini_mcu_pkg::AO_BASE + mini_mcu_pkg::AO_EXIT_VALID_OFS;
    do_xfer(1'b1, 1'b1, mini_mcu_pkg::AO_BASE + mini_mcu_pkg::AO_EXIT_VALUE_OFS, dat,
            4'b0101, w1);
    check("exit_value_port", exit_value_m, exit_value);
    do_xfer(1'b0, 1'b0, mini_mcu_pkg::AO_BASE + mini_mcu_pkg::AO_EXIT_VALUE_OFS, '0, '0, w0);
    do_xfer(1'b1, 1'b1, adr, 32'h1, 4'hf, w1);
    check("exit_valid_set", 32'd1, mini_mcu_pkg::data_t'(exit_valid));
    do_xfer(1'b1, 1'b1, adr, '0, 4'hf, w1);
    check("exit_valid_sticky", 32'd1, mini_mcu_pkg::data_t'(exit_valid));
    do_xfer(1'b0, 1'b0, adr, '0, '0, w0);
    drain();

    test_name = "boot_select";
    adr = mini_mcu_pkg::AO_BASE + mini_mcu_pkg::AO_BOOT_SEL_OFS;
    do_xfer(1'b0, 1'b0, adr, '0, '0, w0);
    boot_sel = 1'b1;
    do_xfer(1'b1, 1'b0, adr, '0, '0, w1);
    drain();

    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // run limit scaled to the transaction count
  initial begin
    #(NUM_XFERS * 20 * CLK_PERIOD + 8 * CLK_PERIOD);
    $display("timeout: transactions did not complete in the allowed time");
    $display("Test failures found");
    $finish;
  end

endmodule

// ==== sim.f ====
hdl/mini_mcu_pkg.sv
hdl/system_bus.sv
hdl/memory_subsystem.sv
hdl/ao_peripheral_subsystem.sv
hdl/mini_mcu.sv
testbench/tb_mini_mcu.sv

// ==== Makefile ====
TOOL     ?= verilator
FLAGS    ?= --timing --assert
TOP      ?= tb_mini_mcu
FILELIST ?= sim.f
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log
FAIL_MSG  = Test failures found

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(TOOL) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); test $$rc -eq 0
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failures"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
